// File: io_cases.txt
// Columns (hex): op master address data expected; op 1 sets switches, 2 writes, 3 reads,
// 4 reads from both masters at once, 5 expects a serial byte, 0 ends; CNT reads use the tally
4 0 0 00000000 00000000
// LED from either master
2 0 0 00000005 00000000
3 1 0 00000000 00000005
2 1 0 FFFFFFF9 00000000
3 0 0 00000000 00000009
// Switches through the synchronizer
1 0 1 0000000A 00000000
3 1 1 00000000 0000000A
1 0 1 00000003 00000000
3 0 1 00000000 00000003
// One serial frame, busy while it runs
2 0 2 000000A5 00000000
3 1 3 00000000 00000001
5 0 0 000000A5 00000000
3 0 3 00000000 00000000
// Overrun on a second byte, then cleared
2 1 2 0000003C 00000000
2 0 2 00000077 00000000
3 1 3 00000000 00000003
2 1 3 00000002 00000000
3 0 3 00000000 00000001
5 0 0 0000003C 00000000
3 1 3 00000000 00000000
// Contention and access counters
4 0 0 00000000 00000009
4 0 4 00000000 00000000
3 0 5 00000000 00000000
4 0 4 00000000 00000000
4 0 5 00000000 00000000
// Unmapped and write-only addresses
3 1 9 00000000 00000000
2 1 E 12345678 00000000
3 0 E 00000000 00000000
3 1 2 00000000 00000000
0 0 0 00000000 00000000

// File: sim.f
+incdir+.
sys_pkg.sv
bus_arbiter.sv
io_regs.sv
uart_tx.sv
bus_monitor.sv
io_sys_top.sv
io_sys_tb.sv

// File: io_sys_tb.sv
// Testbench for the two-master I/O subsystem: case-file driver, serial receiver and checks
`timescale 1ns/10ps
`default_nettype none
`include "sys_cfg.svh"

module io_sys_tb;

	localparam int MAX_CASES    = 64;
	localparam int ACK_TIMEOUT  = 50;
	localparam int BYTE_TIMEOUT = 30 * `SYS_UART_DIV;
	localparam int FRAME_LEN    = 10 * `SYS_UART_DIV;

	logic                clk;
	logic                i_rst;
	logic                i_m0_req;
	logic                i_m0_we;
	sys_pkg::bus_addr_t  i_m0_addr;
	sys_pkg::bus_data_t  i_m0_wdata;
	logic                o_m0_ack;
	sys_pkg::bus_data_t  o_m0_rdata;
	logic                i_m1_req;
	logic                i_m1_we;
	sys_pkg::bus_addr_t  i_m1_addr;
	sys_pkg::bus_data_t  i_m1_wdata;
	logic                o_m1_ack;
	sys_pkg::bus_data_t  o_m1_rdata;
	sys_pkg::led_t       i_sw;
	sys_pkg::led_t       o_led;
	logic                o_uart_txd;

	// Five words per case line: op, master, address, data, expected
	logic [31:0]         case_mem [0:5*MAX_CASES-1];
	logic [7:0]          rx_queue [$];
	logic [9:0]          rx_frame;
	logic                rx_active;
	int                  rx_pos;
	int                  errors;
	int                  checks;
	int                  tally0;
	int                  tally1;
	bit                  timed_out;
	sys_pkg::led_t       led_model;
	sys_pkg::master_id_t last_grant;

	io_sys_top uut (
		.clk(clk), .i_rst(i_rst),
		.i_m0_req(i_m0_req), .i_m0_we(i_m0_we), .i_m0_addr(i_m0_addr),
		.i_m0_wdata(i_m0_wdata), .o_m0_ack(o_m0_ack), .o_m0_rdata(o_m0_rdata),
		.i_m1_req(i_m1_req), .i_m1_we(i_m1_we), .i_m1_addr(i_m1_addr),
		.i_m1_wdata(i_m1_wdata), .o_m1_ack(o_m1_ack), .o_m1_rdata(o_m1_rdata),
		.i_sw(i_sw), .o_led(o_led), .o_uart_txd(o_uart_txd)
	);

	initial clk = 1'b0;
	always #(`SYS_CLK_PERIOD_NS / 2) clk = ~clk;

	// ********************
	// Compare tasks
	// ********************
	task automatic check_data(input string name, input sys_pkg::bus_data_t got,
			input sys_pkg::bus_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_led(input string name, input sys_pkg::led_t got,
			input sys_pkg::led_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%01h, expected 0x%01h", name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("ERROR: timed out waiting for %s", what);
	endtask

	// Counter registers come from the local tally, everything else from the case file
	function automatic sys_pkg::bus_data_t read_expect(input sys_pkg::bus_addr_t addr,
			input sys_pkg::bus_data_t file_exp);
		if (addr == `SYS_REG_CNT0) begin
			return {16'b0, tally0[15:0]};
		end else if (addr == `SYS_REG_CNT1) begin
			return {16'b0, tally1[15:0]};
		end
		return file_exp;
	endfunction

	task automatic count_access(input sys_pkg::master_id_t m);
		if (m == sys_pkg::M0) begin
			tally0++;
		end else begin
			tally1++;
		end
		last_grant = m;
	endtask

	task automatic drive_port(input sys_pkg::master_id_t m, input logic req, input logic we,
			input sys_pkg::bus_addr_t addr, input sys_pkg::bus_data_t wdata);
		if (m == sys_pkg::M0) begin
			i_m0_req   = req;
			i_m0_we    = we;
			i_m0_addr  = addr;
			i_m0_wdata = wdata;
		end else begin
			i_m1_req   = req;
			i_m1_we    = we;
			i_m1_addr  = addr;
			i_m1_wdata = wdata;
		end
	endtask

	// ********************
	// Bus transactions
	// ********************
	task automatic run_access(input sys_pkg::master_id_t m, input logic we,
			input sys_pkg::bus_addr_t addr, input sys_pkg::bus_data_t wdata,
			output sys_pkg::bus_data_t rdata);
		int   cycles;
		logic ack;
		cycles = 0;
		ack = 1'b0;
		rdata = '0;
		drive_port(m, 1'b1, we, addr, wdata);
		while (!ack && cycles < ACK_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			ack = (m == sys_pkg::M0) ? o_m0_ack : o_m1_ack;
		end
		if (!ack) begin
			report_timeout((m == sys_pkg::M0) ? "the m0 acknowledge" : "the m1 acknowledge");
		end else begin
			rdata = (m == sys_pkg::M0) ? o_m0_rdata : o_m1_rdata;
			// First edge only sees the request, latency counts the edges after it
			if (cycles - 1 != 2) begin
				errors++;
				$display("ERROR: acknowledge came %0d cycles after the request, not 2",
					cycles - 1);
			end
			count_access(m);
		end
		drive_port(m, 1'b0, 1'b0, '0, '0);
	endtask

	// Both masters read the same register in the same cycle
	task automatic run_pair(input sys_pkg::bus_addr_t addr, input sys_pkg::bus_data_t file_exp);
		int                  cycles;
		bit                  done0;
		bit                  done1;
		sys_pkg::master_id_t first_exp;
		sys_pkg::master_id_t first_got;
		cycles = 0;
		done0 = 1'b0;
		done1 = 1'b0;
		first_got = sys_pkg::M0;
		first_exp = (last_grant == sys_pkg::M0) ? sys_pkg::M1 : sys_pkg::M0;
		drive_port(sys_pkg::M0, 1'b1, 1'b0, addr, '0);
		drive_port(sys_pkg::M1, 1'b1, 1'b0, addr, '0);
		while (!(done0 && done1) && cycles < 2 * ACK_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (o_m0_ack) begin
				if (!done1) begin
					first_got = sys_pkg::M0;
				end
				check_data("o_m0_rdata", o_m0_rdata, read_expect(addr, file_exp));
				count_access(sys_pkg::M0);
				drive_port(sys_pkg::M0, 1'b0, 1'b0, '0, '0);
				done0 = 1'b1;
			end
			if (o_m1_ack) begin
				if (!done0) begin
					first_got = sys_pkg::M1;
				end
				check_data("o_m1_rdata", o_m1_rdata, read_expect(addr, file_exp));
				count_access(sys_pkg::M1);
				drive_port(sys_pkg::M1, 1'b0, 1'b0, '0, '0);
				done1 = 1'b1;
			end
		end
		drive_port(sys_pkg::M0, 1'b0, 1'b0, '0, '0);
		drive_port(sys_pkg::M1, 1'b0, 1'b0, '0, '0);
		if (!(done0 && done1)) begin
			report_timeout("both acknowledges of a paired access");
		end else if (first_got != first_exp) begin
			errors++;
			$display("FAILED first acknowledge id: got 0x%0h, expected 0x%0h",
				first_got, first_exp);
		end
	endtask

	task automatic expect_byte(input logic [7:0] exp);
		int cycles;
		cycles = 0;
		while (rx_queue.size() == 0 && cycles < BYTE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (rx_queue.size() == 0) begin
			report_timeout("a serial frame");
		end else begin
			check_byte("o_uart_txd byte", rx_queue.pop_front(), exp);
		end
	endtask

	// ********************
	// Serial receiver model
	// ********************
	// Every bit must hold for a full divider period of falling-edge samples
	always @(negedge clk) begin
		if (i_rst) begin
			rx_active = 1'b0;
			rx_pos = 0;
		end else if (!rx_active) begin
			if (o_uart_txd === 1'b0) begin
				rx_active = 1'b1;
				rx_pos = 1;
				rx_frame = 10'b0;
			end
		end else begin
			if (rx_pos % `SYS_UART_DIV == 0) begin
				rx_frame[rx_pos / `SYS_UART_DIV] = o_uart_txd;
			end else if (o_uart_txd !== rx_frame[rx_pos / `SYS_UART_DIV]) begin
				errors++;
				$display("ERROR: serial bit %0d changed before %0d cycles passed",
					rx_pos / `SYS_UART_DIV, `SYS_UART_DIV);
			end
			rx_pos++;
			if (rx_pos == FRAME_LEN) begin
				rx_active = 1'b0;
				if (rx_frame[9] !== 1'b1) begin
					errors++;
					$display("ERROR: serial frame ended without a stop bit");
				end
				rx_queue.push_back(rx_frame[8:1]);
			end
		end
	end

	// ********************
	// Case driver
	// ********************
	initial begin
		int                  idx;
		int                  ncases;
		int unsigned         seed;
		logic [31:0]         op;
		sys_pkg::master_id_t m;
		sys_pkg::bus_addr_t  addr;
		sys_pkg::bus_data_t  dat;
		sys_pkg::bus_data_t  exp;
		sys_pkg::bus_data_t  rdata;
		seed = $urandom(32'h9a03);
		i_rst = 1'b1;
		i_sw = '0;
		drive_port(sys_pkg::M0, 1'b0, 1'b0, '0, '0);
		drive_port(sys_pkg::M1, 1'b0, 1'b0, '0, '0);
		errors = 0;
		checks = 0;
		tally0 = 0;
		tally1 = 0;
		ncases = 0;
		timed_out = 1'b0;
		led_model = '0;
		// Reset leaves M1 as last granted, so M0 wins the first tie
		last_grant = sys_pkg::M1;
		$readmemh("io_cases.txt", case_mem);
		repeat (5) @(negedge clk);
		i_rst = 1'b0;
		check_led("o_led", o_led, '0);
		if (o_m0_ack !== 1'b0 || o_m1_ack !== 1'b0 || o_uart_txd !== 1'b1) begin
			errors++;
			$display("ERROR: acknowledges or serial line not at their idle values after reset");
		end
		for (idx = 0; idx < MAX_CASES && !timed_out; idx++) begin
			op = case_mem[5*idx];
			if ($isunknown(op) || op == 32'h0) begin
				break;
			end
			m = sys_pkg::master_id_t'(case_mem[5*idx+1][0]);
			addr = case_mem[5*idx+2][3:0];
			dat = case_mem[5*idx+3];
			exp = case_mem[5*idx+4];
			ncases++;
			repeat ($urandom_range(3, 1)) @(negedge clk);
			case (op)
				32'h1: begin
					i_sw = dat[3:0];
					repeat (3) @(negedge clk);
				end
				32'h2: begin
					run_access(m, 1'b1, addr, dat, rdata);
					if (addr == `SYS_REG_LED) begin
						led_model = dat[3:0];
					end
					check_led("o_led", o_led, led_model);
				end
				32'h3: begin
					exp = read_expect(addr, exp);
					run_access(m, 1'b0, addr, '0, rdata);
					if (!timed_out) begin
						check_data((m == sys_pkg::M0) ? "o_m0_rdata" : "o_m1_rdata", rdata, exp);
					end
				end
				32'h4: run_pair(addr, exp);
				32'h5: expect_byte(dat[7:0]);
				default: begin
					errors++;
					$display("ERROR: unknown operation %0d in case %0d", op, idx);
				end
			endcase
		end
		if (ncases == 0) begin
			errors++;
			$display("ERROR: no cases were read from io_cases.txt");
		end
		if (!timed_out && rx_queue.size() != 0) begin
			errors++;
			$display("ERROR: %0d serial bytes arrived that no case expected", rx_queue.size());
		end
		$display("Cases: %0d, checks: %0d, errors: %0d", ncases, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: io_sys_top.sv
// Two-master I/O subsystem top: arbiter, registers, serial transmitter and monitor
`timescale 1ns/10ps
`default_nettype none

module io_sys_top (
	input  wire                clk,
	input  wire                i_rst,
	input  wire                i_m0_req,
	input  wire                i_m0_we,
	input  sys_pkg::bus_addr_t i_m0_addr,
	input  sys_pkg::bus_data_t i_m0_wdata,
	output logic               o_m0_ack,
	output sys_pkg::bus_data_t o_m0_rdata,
	input  wire                i_m1_req,
	input  wire                i_m1_we,
	input  sys_pkg::bus_addr_t i_m1_addr,
	input  sys_pkg::bus_data_t i_m1_wdata,
	output logic               o_m1_ack,
	output sys_pkg::bus_data_t o_m1_rdata,
	input  sys_pkg::led_t      i_sw,
	output sys_pkg::led_t      o_led,
	output logic               o_uart_txd
);

	// Shared register access
	logic                acc_strobe;
	logic                acc_we;
	sys_pkg::bus_addr_t  acc_addr;
	sys_pkg::bus_data_t  acc_wdata;
	sys_pkg::master_id_t acc_id;
	sys_pkg::bus_data_t  acc_rdata;

	// Transmitter and counter links
	logic                tx_busy;
	logic                tx_start;
	logic [7:0]          tx_byte;
	sys_pkg::acc_cnt_t   cnt0;
	sys_pkg::acc_cnt_t   cnt1;

	bus_arbiter u_arb (
		.clk(clk), .i_rst(i_rst),
		.i_m0_req(i_m0_req), .i_m0_we(i_m0_we), .i_m0_addr(i_m0_addr),
		.i_m0_wdata(i_m0_wdata), .o_m0_ack(o_m0_ack), .o_m0_rdata(o_m0_rdata),
		.i_m1_req(i_m1_req), .i_m1_we(i_m1_we), .i_m1_addr(i_m1_addr),
		.i_m1_wdata(i_m1_wdata), .o_m1_ack(o_m1_ack), .o_m1_rdata(o_m1_rdata),
		.o_acc_strobe(acc_strobe), .o_acc_we(acc_we), .o_acc_addr(acc_addr),
		.o_acc_wdata(acc_wdata), .o_acc_id(acc_id), .i_acc_rdata(acc_rdata)
	);

	io_regs u_regs (
		.clk(clk), .i_rst(i_rst),
		.i_acc_strobe(acc_strobe), .i_acc_we(acc_we), .i_acc_addr(acc_addr),
		.i_acc_wdata(acc_wdata), .o_acc_rdata(acc_rdata),
		.i_sw(i_sw), .o_led(o_led),
		.i_tx_busy(tx_busy), .o_tx_start(tx_start), .o_tx_byte(tx_byte),
		.i_cnt0(cnt0), .i_cnt1(cnt1)
	);

	uart_tx u_tx (
		.clk(clk), .i_rst(i_rst),
		.i_start(tx_start), .i_byte(tx_byte),
		.o_busy(tx_busy), .o_txd(o_uart_txd)
	);

	bus_monitor u_mon (
		.clk(clk), .i_rst(i_rst),
		.i_acc_strobe(acc_strobe), .i_acc_id(acc_id),
		.i_m0_req(i_m0_req), .i_m0_ack(o_m0_ack),
		.i_m1_req(i_m1_req), .i_m1_ack(o_m1_ack),
		.o_cnt0(cnt0), .o_cnt1(cnt1)
	);

endmodule

`default_nettype wire

// File: bus_monitor.sv
// Per-master access counters and request protocol checks on the register bus
`timescale 1ns/10ps
`default_nettype none

module bus_monitor (
	input  wire                 clk,
	input  wire                 i_rst,
	input  wire                 i_acc_strobe,
	input  sys_pkg::master_id_t i_acc_id,
	input  wire                 i_m0_req,
	input  wire                 i_m0_ack,
	input  wire                 i_m1_req,
	input  wire                 i_m1_ack,
	output sys_pkg::acc_cnt_t   o_cnt0,
	output sys_pkg::acc_cnt_t   o_cnt1
);

	sys_pkg::acc_cnt_t cnt0_q;
	sys_pkg::acc_cnt_t cnt1_q;

	// ********************
	// Counters
	// ********************
	// Update lands after the strobe, so a CNT read sees the earlier total
	always_ff @(posedge clk) begin
		if (i_rst) begin
			cnt0_q <= '0;
			cnt1_q <= '0;
		end else if (i_acc_strobe) begin
			if (i_acc_id == sys_pkg::M0) begin
				if (cnt0_q != '1) begin
					cnt0_q <= cnt0_q + sys_pkg::acc_cnt_t'(1);
				end
			end else if (cnt1_q != '1) begin
				cnt1_q <= cnt1_q + sys_pkg::acc_cnt_t'(1);
			end
		end
	end

	assign o_cnt0 = cnt0_q;
	assign o_cnt1 = cnt1_q;

	// ********************
	// Protocol checks
	// ********************
	// A request may only fall once its acknowledge has been seen
	a_m0_hold: assert property (@(posedge clk) disable iff (i_rst)
		$fell(i_m0_req) |-> (i_m0_ack || $past(i_m0_ack)));
	a_m1_hold: assert property (@(posedge clk) disable iff (i_rst)
		$fell(i_m1_req) |-> (i_m1_ack || $past(i_m1_ack)));

	// Strobe only for a master that is still requesting
	a_strobe_owner: assert property (@(posedge clk) disable iff (i_rst)
		i_acc_strobe |-> ((i_acc_id == sys_pkg::M0) ? i_m0_req : i_m1_req));

endmodule

`default_nettype wire

// File: uart_tx.sv
// 8N1 serial transmitter with a clock-cycle baud divider
`timescale 1ns/10ps
`default_nettype none
`include "sys_cfg.svh"

module uart_tx (
	input  wire        clk,
	input  wire        i_rst,
	input  wire        i_start,
	input  wire  [7:0] i_byte,
	output logic       o_busy,
	output logic       o_txd
);

	localparam int unsigned DIV        = `SYS_UART_DIV;
	localparam int unsigned CNT_W      = $clog2(DIV);
	localparam int unsigned FRAME_BITS = 10;

	logic             busy_q;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_cnt;
	logic [9:0]       shift_q;
	logic             bit_end;

	// Last cycle of the current bit
	assign bit_end = (baud_cnt == CNT_W'(DIV - 1));

	// ********************
	// Bit timing
	// ********************
	always_ff @(posedge clk) begin
		if (i_rst) begin
			busy_q   <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else if (!busy_q) begin
			if (i_start) begin
				busy_q   <= 1'b1;
				baud_cnt <= '0;
				bit_cnt  <= '0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			// Frame ends after the stop bit
			if (bit_cnt == 4'(FRAME_BITS - 1)) begin
				busy_q <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			baud_cnt <= baud_cnt + CNT_W'(1);
		end
	end

	// ********************
	// Frame shifter
	// ********************
	// Stop bit, data, start bit; bit 0 goes out first
	always_ff @(posedge clk) begin
		if (i_start && !busy_q) begin
			shift_q <= {1'b1, i_byte, 1'b0};
		end else if (busy_q && bit_end) begin
			shift_q <= {1'b1, shift_q[9:1]};
		end
	end

	assign o_busy = busy_q;

	// Line idles high
	assign o_txd = busy_q ? shift_q[0] : 1'b1;

endmodule

`default_nettype wire

// File: io_regs.sv
// Register block with LED, switch, serial transmit, status and counter registers
`timescale 1ns/10ps
`default_nettype none
`include "sys_cfg.svh"

module io_regs (
	input  wire                clk,
	input  wire                i_rst,
	input  wire                i_acc_strobe,
	input  wire                i_acc_we,
	input  sys_pkg::bus_addr_t i_acc_addr,
	input  sys_pkg::bus_data_t i_acc_wdata,
	output sys_pkg::bus_data_t o_acc_rdata,
	input  sys_pkg::led_t      i_sw,
	output sys_pkg::led_t      o_led,
	input  wire                i_tx_busy,
	output logic               o_tx_start,
	output logic [7:0]         o_tx_byte,
	input  sys_pkg::acc_cnt_t  i_cnt0,
	input  sys_pkg::acc_cnt_t  i_cnt1
);

	sys_pkg::led_t led_q;
	sys_pkg::led_t sw_meta;
	sys_pkg::led_t sw_sync;
	logic          overrun_q;
	logic          wr_led;
	logic          wr_tx;
	logic          wr_status;

	// ********************
	// Write decode
	// ********************
	assign wr_led    = i_acc_strobe && i_acc_we && (i_acc_addr == `SYS_REG_LED);
	assign wr_tx     = i_acc_strobe && i_acc_we && (i_acc_addr == `SYS_REG_TXDATA);
	assign wr_status = i_acc_strobe && i_acc_we && (i_acc_addr == `SYS_REG_STATUS);

	// A byte only goes out when the transmitter is free
	assign o_tx_start = wr_tx && !i_tx_busy;
	assign o_tx_byte  = i_acc_wdata[7:0];

	always_ff @(posedge clk) begin
		if (i_rst) begin
			led_q     <= '0;
			overrun_q <= 1'b0;
		end else begin
			if (wr_led) begin
				led_q <= i_acc_wdata[3:0];
			end
			// Sticky until software writes 1 to bit 1 of STATUS
			if (wr_tx && i_tx_busy) begin
				overrun_q <= 1'b1;
			end else if (wr_status && i_acc_wdata[1]) begin
				overrun_q <= 1'b0;
			end
		end
	end

	assign o_led = led_q;

	// Two-flop synchronizer for the asynchronous switches
	always_ff @(posedge clk) begin
		sw_meta <= i_sw;
		sw_sync <= sw_meta;
	end

	// ********************
	// Read mux
	// ********************
	// TXDATA is write only and reads zero like unmapped space
	always_comb begin
		case (i_acc_addr)
			`SYS_REG_LED:    o_acc_rdata = {28'b0, led_q};
			`SYS_REG_SW:     o_acc_rdata = {28'b0, sw_sync};
			`SYS_REG_STATUS: o_acc_rdata = {30'b0, overrun_q, i_tx_busy};
			`SYS_REG_CNT0:   o_acc_rdata = {16'b0, i_cnt0};
			`SYS_REG_CNT1:   o_acc_rdata = {16'b0, i_cnt1};
			default:         o_acc_rdata = '0;
		endcase
	end

	// The transmitter must be idle at a start and report busy right after
	a_start_idle: assert property (@(posedge clk) disable iff (i_rst)
		o_tx_start |-> !i_tx_busy ##1 i_tx_busy);

endmodule

`default_nettype wire

// File: bus_arbiter.sv
// Round-robin arbiter joining two master ports onto one register access
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
	input  wire                 clk,
	input  wire                 i_rst,
	input  wire                 i_m0_req,
	input  wire                 i_m0_we,
	input  sys_pkg::bus_addr_t  i_m0_addr,
	input  sys_pkg::bus_data_t  i_m0_wdata,
	output logic                o_m0_ack,
	output sys_pkg::bus_data_t  o_m0_rdata,
	input  wire                 i_m1_req,
	input  wire                 i_m1_we,
	input  sys_pkg::bus_addr_t  i_m1_addr,
	input  sys_pkg::bus_data_t  i_m1_wdata,
	output logic                o_m1_ack,
	output sys_pkg::bus_data_t  o_m1_rdata,
	output logic                o_acc_strobe,
	output logic                o_acc_we,
	output sys_pkg::bus_addr_t  o_acc_addr,
	output sys_pkg::bus_data_t  o_acc_wdata,
	output sys_pkg::master_id_t o_acc_id,
	input  sys_pkg::bus_data_t  i_acc_rdata
);

	// Phases of one access from grant to acknowledge
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_GRANT,
		PH_STROBE,
		PH_ACK
	} phase_t;

	phase_t              phase;
	sys_pkg::master_id_t last_id;
	logic                pick_m1;
	logic                cur_we;
	sys_pkg::bus_addr_t  cur_addr;
	sys_pkg::bus_data_t  cur_wdata;
	sys_pkg::bus_data_t  rdata_q;

	// With both requesting the master not granted last wins
	always_comb begin
		if (i_m0_req && i_m1_req) begin
			pick_m1 = (last_id == sys_pkg::M0);
		end else begin
			pick_m1 = i_m1_req;
		end
	end

	// ********************
	// Phase control
	// ********************
	// Reset leaves last_id at M1 so that M0 goes first
	always_ff @(posedge clk) begin
		if (i_rst) begin
			phase   <= PH_IDLE;
			last_id <= sys_pkg::M1;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (i_m0_req || i_m1_req) begin
						phase   <= PH_GRANT;
						last_id <= pick_m1 ? sys_pkg::M1 : sys_pkg::M0;
					end
				end
				PH_GRANT:  phase <= PH_STROBE;
				PH_STROBE: phase <= PH_ACK;
				// Requester still holds req here and gets no new grant
				default:   phase <= PH_IDLE;
			endcase
		end
	end

	// Access fields are captured while idle and read data at the strobe
	always_ff @(posedge clk) begin
		if (phase == PH_IDLE) begin
			cur_we    <= pick_m1 ? i_m1_we : i_m0_we;
			cur_addr  <= pick_m1 ? i_m1_addr : i_m0_addr;
			cur_wdata <= pick_m1 ? i_m1_wdata : i_m0_wdata;
		end
		if (phase == PH_STROBE) begin
			rdata_q <= i_acc_rdata;
		end
	end

	assign o_acc_strobe = (phase == PH_STROBE);
	assign o_acc_we     = cur_we;
	assign o_acc_addr   = cur_addr;
	assign o_acc_wdata  = cur_wdata;
	assign o_acc_id     = last_id;

	assign o_m0_ack   = (phase == PH_ACK) && (last_id == sys_pkg::M0);
	assign o_m1_ack   = (phase == PH_ACK) && (last_id == sys_pkg::M1);
	assign o_m0_rdata = rdata_q;
	assign o_m1_rdata = rdata_q;

	// ********************
	// Checks
	// ********************
	a_one_ack: assert property (@(posedge clk) disable iff (i_rst)
		!(o_m0_ack && o_m1_ack));

endmodule

`default_nettype wire

// File: sys_pkg.sv
// Shared bus, identifier and counter types for the I/O subsystem
`default_nettype none

package sys_pkg;

	// ********************
	// Register bus
	// ********************

	// Word address of a register
	typedef logic [3:0] bus_addr_t;

	// Bus data word
	typedef logic [31:0] bus_data_t;

	// Owner of an access
	typedef enum logic {
		M0 = 1'b0,
		M1 = 1'b1
	} master_id_t;

	// ********************
	// Peripheral values
	// ********************

	// LED or switch nibble
	typedef logic [3:0] led_t;

	// Per-master access count
	typedef logic [15:0] acc_cnt_t;

endpackage

`default_nettype wire

// File: sys_cfg.svh
// I/O subsystem configuration: clock, serial timing and register map
`ifndef SYS_CFG_SVH
`define SYS_CFG_SVH

// ********************
// Clock and serial timing
// ********************

// System clock period in ns
`define SYS_CLK_PERIOD_NS 100

// Nominal serial rate
`define SYS_UART_BAUD 115200

// Clock cycles per serial bit, far faster than the nominal rate
`define SYS_UART_DIV 10

// ********************
// Register map (word addresses)
// ********************
`define SYS_REG_LED    4'h0
`define SYS_REG_SW     4'h1
`define SYS_REG_TXDATA 4'h2
`define SYS_REG_STATUS 4'h3
`define SYS_REG_CNT0   4'h4
`define SYS_REG_CNT1   4'h5

`endif
